// ==== all.f ====
simmem_pkg.sv
simmem_if.sv
simmem_free_list.sv
simmem_list_ctrl.sv
simmem_msg_ram.sv
simmem_release_stage.sv
simmem_linkedlist_bank.sv
tb_simmem_bank.sv

// ==== run.sh ====
#!/bin/sh
# Builds the message bank testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=obj_dir/Vtb_simmem_bank

verilator --binary --timing --timescale 1ns/1ps -f all.f \
  --top-module tb_simmem_bank -o Vtb_simmem_bank
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

"./$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "Verification passed" "$LOG"; then
  echo "Result: PASS"
  exit 0
fi

echo "Result: FAIL"
exit 1

// ==== tb_simmem_bank.sv ====
// Testbench for the linked list message bank
// Directed tests with per-identifier reference queues and an output monitor

module tb_simmem_bank;
  timeunit 1ns;
  timeprecision 100ps;

  import simmem_pkg::*;

  localparam int WaitLimit   = 200;
  localparam int DrainLimit  = 4000;
  localparam int ReadyOn     = 0;
  localparam int ReadyRandom = 1;

  logic                clk_i;
  logic                rst_ni;
  logic [NumIds-1:0]   release_en_i;
  logic                in_valid_i;
  logic                in_ready_o;
  logic [MsgWidth-1:0] data_i;
  logic                out_valid_o;
  logic                out_ready_i;
  logic [MsgWidth-1:0] data_o;

  // Expected messages per identifier, in arrival order
  logic [MsgWidth-1:0] exp_q [NumIds][$];
  logic [IdWidth-1:0]  out_ids [$];
  logic [15:0]         data_lfsr;
  logic [15:0]         ready_lfsr;
  int                  ready_mode;
  logic                stall_active;
  logic [MsgWidth-1:0] stall_data;
  int                  err_count;
  int                  check_count;
  int                  test_count;
  int                  out_count;

  simmem_linkedlist_bank simmem_linkedlist_bank_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .release_en_i (release_en_i),
    .in_valid_i   (in_valid_i),
    .in_ready_o   (in_ready_o),
    .data_i       (data_i),
    .out_valid_o  (out_valid_o),
    .out_ready_i  (out_ready_i),
    .data_o       (data_o)
  );

  always #10 clk_i = ~clk_i;

  // 16-bit Galois LFSR, taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] state);
    logic [15:0] next;
    next = state >> 1;
    if (state[0]) begin
      next = next ^ 16'hB400;
    end
    return next;
  endfunction

  task automatic take_bits(input int n, output logic [MsgWidth-1:0] value);
    value = '0;
    for (int i = 0; i < n; i++) begin
      value     = {value[MsgWidth-2:0], data_lfsr[0]};
      data_lfsr = lfsr_step(data_lfsr);
    end
  endtask

  task automatic check_equal(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    check_count++;
    if (actual !== expected) begin
      err_count++;
      $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, actual, expected);
    end
  endtask

  function automatic int pending_total();
    int total;
    total = 0;
    for (int i = 0; i < NumIds; i++) begin
      total += exp_q[i].size();
    end
    return total;
  endfunction

  // One cycle: sample outputs at the falling edge, check them, drive out_ready_i
  task automatic step_cycle();
    logic [IdWidth-1:0] id;
    @(negedge clk_i);
    if (stall_active) begin
      check_equal("out_valid_o", 32'(out_valid_o), 32'd1);
      check_equal("data_o", data_o, stall_data);
    end
    if (ready_mode == ReadyRandom) begin
      out_ready_i = ready_lfsr[0];
      ready_lfsr  = lfsr_step(ready_lfsr);
    end else begin
      out_ready_i = 1'b1;
    end
    stall_active = out_valid_o && !out_ready_i;
    stall_data   = data_o;
    if (out_valid_o && out_ready_i) begin
      id = data_o[IdWidth-1:0];
      out_count++;
      out_ids.push_back(id);
      if (!release_en_i[id]) begin
        err_count++;
        $display("Output for identifier %0d while its release was disabled", id);
      end
      if (exp_q[id].size() == 0) begin
        err_count++;
        $display("Unexpected output 0x%08h for identifier %0d", data_o, id);
      end else begin
        check_equal("data_o", data_o, exp_q[id].pop_front());
      end
    end
  endtask

  task automatic send_msg(input logic [IdWidth-1:0] id, input logic [PayloadWidth-1:0] payload);
    int waited;
    waited     = 0;
    in_valid_i = 1'b1;
    data_i     = {payload, id};
    while (!in_ready_o && waited < WaitLimit) begin
      step_cycle();
      waited++;
    end
    if (in_ready_o) begin
      exp_q[id].push_back({payload, id});
      step_cycle();
    end else begin
      err_count++;
      $display("Timeout: in_ready_o stayed low for %0d cycles", WaitLimit);
    end
    in_valid_i = 1'b0;
  endtask

  task automatic send_random(input logic [IdWidth-1:0] id);
    logic [MsgWidth-1:0] bits;
    take_bits(PayloadWidth, bits);
    send_msg(id, bits[PayloadWidth-1:0]);
  endtask

  task automatic drain_all();
    int waited;
    waited = 0;
    while ((pending_total() > 0 || out_valid_o) && waited < DrainLimit) begin
      step_cycle();
      waited++;
    end
    if (pending_total() > 0) begin
      err_count++;
      $display("Timeout: %0d messages never came out", pending_total());
    end
  endtask

  task automatic finish_test(input string name, input int errs_before);
    test_count++;
    $display("[TEST] %s: %0d errors", name, err_count - errs_before);
  endtask

  task automatic test_reset_state();
    int errs;
    errs = err_count;
    check_equal("out_valid_o", 32'(out_valid_o), 32'd0);
    check_equal("in_ready_o", 32'(in_ready_o), 32'd1);
    finish_test("reset_state", errs);
  endtask

  task automatic test_single_id_order();
    int errs;
    errs         = err_count;
    release_en_i = '1;
    for (int i = 0; i < 8; i++) begin
      send_random(IdWidth'(5));
    end
    drain_all();
    finish_test("single_id_order", errs);
  endtask

  task automatic test_release_gating();
    int errs;
    int waited;
    int seen;
    errs         = err_count;
    release_en_i = '0;
    for (int i = 0; i < 3; i++) begin
      send_random(IdWidth'(4));
      send_random(IdWidth'(11));
    end
    seen = 0;
    for (int i = 0; i < 20; i++) begin
      step_cycle();
      seen += int'(out_valid_o);
    end
    check_equal("out_valid_o cycles while disabled", 32'(seen), 32'd0);
    release_en_i = NumIds'(1) << 11;
    waited = 0;
    while (exp_q[11].size() > 0 && waited < WaitLimit) begin
      step_cycle();
      waited++;
    end
    repeat (10) step_cycle();
    check_equal("pending messages of id 11", 32'(exp_q[11].size()), 32'd0);
    check_equal("pending messages of id 4", 32'(exp_q[4].size()), 32'd3);
    release_en_i = '1;
    drain_all();
    finish_test("release_gating", errs);
  endtask

  task automatic test_id_priority();
    int errs;
    logic [IdWidth-1:0] ids [10];
    errs         = err_count;
    ids          = '{4'd9, 4'd3, 4'd12, 4'd3, 4'd0, 4'd9, 4'd12, 4'd7, 4'd0, 4'd3};
    release_en_i = '0;
    out_ids.delete();
    foreach (ids[i]) begin
      send_random(ids[i]);
    end
    release_en_i = '1;
    drain_all();
    check_equal("output count", 32'(out_ids.size()), 32'd10);
    for (int i = 1; i < out_ids.size(); i++) begin
      if (out_ids[i] < out_ids[i-1]) begin
        err_count++;
        $display("Identifier %0d came out after identifier %0d", out_ids[i], out_ids[i-1]);
      end
    end
    finish_test("id_priority", errs);
  endtask

  task automatic test_capacity_limit();
    int errs;
    int waited;
    int start_count;
    errs         = err_count;
    release_en_i = '0;
    for (int i = 0; i < Capacity; i++) begin
      check_equal("in_ready_o", 32'(in_ready_o), 32'd1);
      send_random(IdWidth'(15 - i));
    end
    check_equal("in_ready_o when full", 32'(in_ready_o), 32'd0);
    // Identifier 0 holds exactly one message
    release_en_i = NumIds'(1);
    start_count  = out_count;
    waited       = 0;
    while (out_count == start_count && waited < WaitLimit) begin
      step_cycle();
      waited++;
    end
    step_cycle();
    check_equal("transfers", 32'(out_count - start_count), 32'd1);
    check_equal("in_ready_o after one transfer", 32'(in_ready_o), 32'd1);
    release_en_i = '1;
    drain_all();
    finish_test("capacity_limit", errs);
  endtask

  task automatic test_backpressure();
    int errs;
    logic [MsgWidth-1:0] bits;
    errs         = err_count;
    release_en_i = '1;
    ready_mode   = ReadyRandom;
    for (int i = 0; i < 40; i++) begin
      take_bits(IdWidth, bits);
      send_random(bits[IdWidth-1:0]);
    end
    drain_all();
    ready_mode = ReadyOn;
    finish_test("backpressure", errs);
  endtask

  initial begin
    clk_i        = 1'b0;
    rst_ni       = 1'b0;
    release_en_i = '0;
    in_valid_i   = 1'b0;
    data_i       = '0;
    out_ready_i  = 1'b0;
    data_lfsr    = 16'd33152;
    ready_lfsr   = 16'd33152;
    ready_mode   = ReadyOn;
    stall_active = 1'b0;
    stall_data   = '0;
    err_count    = 0;
    check_count  = 0;
    test_count   = 0;
    out_count    = 0;
    repeat (16) @(negedge clk_i);
    rst_ni = 1'b1;
    test_reset_state();
    test_single_id_order();
    test_release_gating();
    test_id_priority();
    test_capacity_limit();
    test_backpressure();
    $display("Tests: %0d, checks: %0d, errors: %0d", test_count, check_count, err_count);
    if (err_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// ==== simmem_linkedlist_bank.sv ====
// Linked list message bank for the simulated memory controller
// Messages are stored per identifier in arrival order and released for the
// lowest enabled identifier first

module simmem_linkedlist_bank (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic [simmem_pkg::NumIds-1:0]   release_en_i,
  input  logic                            in_valid_i,
  output logic                            in_ready_o,
  input  logic [simmem_pkg::MsgWidth-1:0] data_i,
  output logic                            out_valid_o,
  input  logic                            out_ready_i,
  output logic [simmem_pkg::MsgWidth-1:0] data_o
);

  import simmem_pkg::*;

  slot_if slot_bus ();
  ram_if  ram_bus ();
  pop_if  pop_bus ();

  logic                    accept;
  logic [IdWidth-1:0]      in_id;
  logic [PayloadWidth-1:0] in_payload;

  // Input is taken whenever a slot is free
  assign in_ready_o = slot_bus.alloc_valid;
  assign accept     = in_valid_i && slot_bus.alloc_valid;
  assign in_id      = data_i[IdWidth-1:0];
  assign in_payload = data_i[MsgWidth-1:IdWidth];

  simmem_free_list free_list_inst (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .slot   (slot_bus.provider)
  );

  simmem_list_ctrl list_ctrl_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .in_valid_i   (accept),
    .in_id_i      (in_id),
    .in_payload_i (in_payload),
    .slot         (slot_bus.user),
    .ram          (ram_bus.driver),
    .pop          (pop_bus.provider)
  );

  simmem_msg_ram msg_ram_inst (
    .clk_i (clk_i),
    .ram   (ram_bus.memory)
  );

  simmem_release_stage release_stage_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .release_en_i (release_en_i),
    .pop          (pop_bus.requester),
    .rd_payload_i (ram_bus.rd_payload),
    .out_valid_o  (out_valid_o),
    .out_ready_i  (out_ready_i),
    .data_o       (data_o)
  );

endmodule

// ==== simmem_release_stage.sv ====
// Release stage of the message bank
// Pops the lowest enabled non-empty identifier and registers the message read
// back from storage for the output handshake

module simmem_release_stage (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic [simmem_pkg::NumIds-1:0]       release_en_i,
  pop_if.requester                            pop,
  input  logic [simmem_pkg::PayloadWidth-1:0] rd_payload_i,
  output logic                                out_valid_o,
  input  logic                                out_ready_i,
  output logic [simmem_pkg::MsgWidth-1:0]     data_o
);

  import simmem_pkg::*;

  logic [NumIds-1:0]   eligible;
  logic [IdWidth-1:0]  sel_id;
  logic                reg_free;
  logic                pop_fire;

  // A popped message is on its way from the RAM
  logic                pending_q;
  logic [IdWidth-1:0]  pend_id_q;
  logic                out_valid_q;
  logic [MsgWidth-1:0] out_data_q;

  assign eligible = pop.nonempty & release_en_i;

  // Lowest eligible identifier
  always_comb begin
    sel_id = '0;
    for (int i = NumIds - 1; i >= 0; i--) begin
      if (eligible[i]) begin
        sel_id = IdWidth'(i);
      end
    end
  end

  // Register is free once it is empty or drained on this edge, and no
  // earlier pop is still due to land in it
  assign reg_free = !pending_q && (!out_valid_q || out_ready_i);

  assign pop.pop_valid = (|eligible) && reg_free;
  assign pop.pop_id    = sel_id;
  assign pop_fire      = pop.pop_valid && pop.pop_ready;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q   <= 1'b0;
      out_valid_q <= 1'b0;
    end else begin
      pending_q <= pop_fire;
      if (pending_q) begin
        out_valid_q <= 1'b1;
      end else if (out_ready_i) begin
        out_valid_q <= 1'b0;
      end
    end
  end

  // Identifier goes back into the low bits of the message
  always_ff @(posedge clk_i) begin
    if (pop_fire) begin
      pend_id_q <= pop.pop_id;
    end
    if (pending_q) begin
      out_data_q <= {rd_payload_i, pend_id_q};
    end
  end

  assign out_valid_o = out_valid_q;
  assign data_o      = out_data_q;

endmodule

// ==== simmem_msg_ram.sv ====
// Message storage of the bank
// Payload and next-pointer arrays, written synchronously, read through a
// registered port that holds its value between reads

module simmem_msg_ram (
  input  logic   clk_i,
  ram_if.memory  ram
);

  import simmem_pkg::*;

  logic [PayloadWidth-1:0] payload_mem [Capacity];
  logic [AddrWidth-1:0]    next_mem    [Capacity];

  logic [PayloadWidth-1:0] rd_payload_q;
  logic [AddrWidth-1:0]    rd_next_q;

  always_ff @(posedge clk_i) begin
    if (ram.wr_en) begin
      payload_mem[ram.wr_addr] <= ram.wr_payload;
    end
    // Links the old tail of a list to the slot written above
    if (ram.link_en) begin
      next_mem[ram.link_addr] <= ram.link_next;
    end
  end

  // Read returns the stored values from before this edge
  always_ff @(posedge clk_i) begin
    if (ram.rd_en) begin
      rd_payload_q <= payload_mem[ram.rd_addr];
      rd_next_q    <= next_mem[ram.rd_addr];
    end
  end

  assign ram.rd_payload = rd_payload_q;
  assign ram.rd_next    = rd_next_q;

endmodule

// ==== simmem_list_ctrl.sv ====
// Linked list control of the message bank
// Keeps head, tail and length for every identifier, links new messages to the
// tail of their list and unlinks the head on a pop

module simmem_list_ctrl (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              in_valid_i,
  input  logic [simmem_pkg::IdWidth-1:0]    in_id_i,
  input  logic [simmem_pkg::PayloadWidth-1:0] in_payload_i,
  slot_if.user                              slot,
  ram_if.driver                             ram,
  pop_if.provider                           pop
);

  import simmem_pkg::*;

  logic [AddrWidth-1:0] head_q [NumIds];
  logic [AddrWidth-1:0] head_d [NumIds];
  logic [AddrWidth-1:0] tail_q [NumIds];
  logic [AddrWidth-1:0] tail_d [NumIds];
  logic [LenWidth-1:0]  len_q  [NumIds];
  logic [LenWidth-1:0]  len_d  [NumIds];
  // Head waits for the next pointer read at the last pop
  logic [NumIds-1:0]    refill_q;
  logic [NumIds-1:0]    refill_d;

  logic                 pop_fire;
  logic [AddrWidth-1:0] pop_head;
  logic                 in_list_empty;

  assign pop_fire = pop.pop_valid & pop.pop_ready;
  assign pop_head = head_q[pop.pop_id];

  // A list whose only entry is popped on this edge counts as empty for the
  // incoming message, so the new slot becomes the head and nothing is linked
  assign in_list_empty = (len_q[in_id_i] == '0) ||
                         (pop_fire && (pop.pop_id == in_id_i) &&
                          (len_q[in_id_i] == LenWidth'(1)));

  for (genvar g = 0; g < NumIds; g++) begin : gen_nonempty
    assign pop.nonempty[g] = (len_q[g] != '0) && !refill_q[g];
  end

  assign pop.pop_ready = pop.nonempty[pop.pop_id];

  // Slot allocation and release
  assign slot.alloc_take = in_valid_i;
  assign slot.free_en    = pop_fire;
  assign slot.free_addr  = pop_head;

  // New payload goes to the allocated slot, old tail points at it
  assign ram.wr_en      = in_valid_i;
  assign ram.wr_addr    = slot.alloc_addr;
  assign ram.wr_payload = in_payload_i;
  assign ram.link_en    = in_valid_i && !in_list_empty;
  assign ram.link_addr  = tail_q[in_id_i];
  assign ram.link_next  = slot.alloc_addr;
  assign ram.rd_en      = pop_fire;
  assign ram.rd_addr    = pop_head;

  always_comb begin
    for (int i = 0; i < NumIds; i++) begin
      head_d[i]   = head_q[i];
      tail_d[i]   = tail_q[i];
      len_d[i]    = len_q[i];
      refill_d[i] = 1'b0;

      if (refill_q[i]) begin
        head_d[i] = ram.rd_next;
      end

      if (pop_fire && (pop.pop_id == IdWidth'(i))) begin
        len_d[i]    = len_d[i] - LenWidth'(1);
        refill_d[i] = len_q[i] > LenWidth'(1);
      end

      if (in_valid_i && (in_id_i == IdWidth'(i))) begin
        len_d[i]  = len_d[i] + LenWidth'(1);
        tail_d[i] = slot.alloc_addr;
        if (in_list_empty) begin
          head_d[i] = slot.alloc_addr;
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NumIds; i++) begin
        head_q[i] <= '0;
        tail_q[i] <= '0;
        len_q[i]  <= '0;
      end
      refill_q <= '0;
    end else begin
      head_q   <= head_d;
      tail_q   <= tail_d;
      len_q    <= len_d;
      refill_q <= refill_d;
    end
  end

endmodule

// ==== simmem_free_list.sv ====
// Free slot tracker for the shared message storage
// One occupancy bit per slot, the lowest free slot is offered for allocation

module simmem_free_list (
  input  logic    clk_i,
  input  logic    rst_ni,
  slot_if.provider slot
);

  import simmem_pkg::*;

  logic [Capacity-1:0]  occ_q;
  logic [Capacity-1:0]  occ_d;
  logic [AddrWidth-1:0] lowest_free;

  // Priority encoder, the scan runs downwards so the lowest free slot wins
  always_comb begin
    lowest_free = '0;
    for (int i = Capacity - 1; i >= 0; i--) begin
      if (!occ_q[i]) begin
        lowest_free = AddrWidth'(i);
      end
    end
  end

  assign slot.alloc_valid = ~&occ_q;
  assign slot.alloc_addr  = lowest_free;

  // Freed and taken slots are never the same one:
  // a taken slot is free, a freed slot is occupied
  always_comb begin
    occ_d = occ_q;
    if (slot.free_en) begin
      occ_d[slot.free_addr] = 1'b0;
    end
    if (slot.alloc_take) begin
      occ_d[slot.alloc_addr] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      occ_q <= '0;
    end else begin
      occ_q <= occ_d;
    end
  end

endmodule

// ==== simmem_if.sv ====
// Internal buses of the message bank
// Slot allocation, message RAM access and per-identifier head pop

interface slot_if;
  import simmem_pkg::*;

  logic                 alloc_valid;
  logic [AddrWidth-1:0] alloc_addr;
  logic                 alloc_take;
  logic                 free_en;
  logic [AddrWidth-1:0] free_addr;

  modport provider (output alloc_valid, alloc_addr, input alloc_take, free_en, free_addr);
  modport user (input alloc_valid, alloc_addr, output alloc_take, free_en, free_addr);
endinterface

interface ram_if;
  import simmem_pkg::*;

  logic                    wr_en;
  logic [AddrWidth-1:0]    wr_addr;
  logic [PayloadWidth-1:0] wr_payload;
  // Next pointer of the old tail
  logic                    link_en;
  logic [AddrWidth-1:0]    link_addr;
  logic [AddrWidth-1:0]    link_next;
  logic                    rd_en;
  logic [AddrWidth-1:0]    rd_addr;
  logic [PayloadWidth-1:0] rd_payload;
  logic [AddrWidth-1:0]    rd_next;

  modport driver (output wr_en, wr_addr, wr_payload, link_en, link_addr, link_next,
                  output rd_en, rd_addr, input rd_next);
  modport memory (input wr_en, wr_addr, wr_payload, link_en, link_addr, link_next,
                  input rd_en, rd_addr, output rd_payload, rd_next);
endinterface

interface pop_if;
  import simmem_pkg::*;

  logic [NumIds-1:0]  nonempty;
  logic               pop_valid;
  logic [IdWidth-1:0] pop_id;
  logic               pop_ready;

  modport requester (input nonempty, pop_ready, output pop_valid, pop_id);
  modport provider (output nonempty, pop_ready, input pop_valid, pop_id);
endinterface

// ==== simmem_pkg.sv ====
// Message bank sizes for the simulated memory controller
// Holds the identifier, message and storage dimensions with their derived widths

package simmem_pkg;

  // Identifier field, carried in the low bits of every message
  localparam int IdWidth = 4;

  // One linked list per identifier
  localparam int NumIds = 2 ** IdWidth;

  // Full message as seen on the ports, identifier included
  localparam int MsgWidth = 32;

  // Only the part above the identifier is kept in storage,
  // the identifier is implied by the list a slot belongs to
  localparam int PayloadWidth = MsgWidth - IdWidth;

  // Storage slots shared by all lists
  localparam int Capacity = 16;

  // Slot address and next-pointer width
  localparam int AddrWidth = $clog2(Capacity);

  // List length counter, one bit wider so that a list can hold every slot
  localparam int LenWidth = AddrWidth + 1;

endpackage
